// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_bpu
FILELIST := filelist.f
LOG      := sim.log
FAIL_MSG := Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), fail if $(LOG) reports failure"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED"; \
		exit 1; \
	fi
	@echo "test PASSED"

clean:
	rm -rf obj_dir $(LOG)

// File: design/bimodal_table.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bimodal_table (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t rd_pc_i,
    output logic           rd_taken_o,
    input  logic           upd_valid_i,
    input  bpu_pkg::addr_t upd_pc_i,
    input  logic           upd_taken_i
);

    localparam int IDX_W = $clog2(`BPU_BIM_ENTRIES);

    bpu_pkg::ctr_t ctr_q [`BPU_BIM_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    bpu_pkg::ctr_t    upd_ctr;

    // word-aligned pc bits select the counter
    assign rd_idx  = rd_pc_i[IDX_W+1:2];
    assign upd_idx = upd_pc_i[IDX_W+1:2];

    assign rd_taken_o = ctr_q[rd_idx][1];  // msb is the direction
    assign upd_ctr    = ctr_q[upd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // weakly not taken everywhere
            for (int i = 0; i < `BPU_BIM_ENTRIES; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else if (upd_valid_i) begin
            if (upd_taken_i) begin
                if (upd_ctr != 2'd3) begin
                    ctr_q[upd_idx] <= upd_ctr + 2'd1;
                end
            end else begin
                if (upd_ctr != 2'd0) begin
                    ctr_q[upd_idx] <= upd_ctr - 2'd1;
                end
            end
        end
    end

endmodule

// File: design/bpu_cfg.svh
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// address and instruction width
`define BPU_XLEN 32

// bimodal direction table, indexed by pc[7:2]
`define BPU_BIM_ENTRIES 64

// direct-mapped btb, indexed by pc[5:2], tag is pc[31:6]
`define BPU_BTB_ENTRIES 16

// return address stack
`define BPU_RAS_DEPTH 8

`endif

// File: design/bpu_pkg.sv
`include "bpu_cfg.svh"

package bpu_pkg;

    typedef logic [`BPU_XLEN-1:0] addr_t;

    typedef logic [1:0] ctr_t;  // 2 and 3 mean taken

    // major opcodes of the control transfers
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    // one fetched word, read through whichever format applies
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } inst_u;

endpackage

// File: design/bpu_top.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_top (
    input  logic                 clk,
    input  logic                 rst,
    // fetch
    input  bpu_pkg::addr_t       if_pc_i,
    input  logic [`BPU_XLEN-1:0] if_inst_i,
    // execute feedback
    input  logic                 ex_valid_i,
    input  logic                 ex_taken_i,
    input  bpu_pkg::addr_t       ex_pc_i,
    input  logic [`BPU_XLEN-1:0] ex_inst_i,
    input  bpu_pkg::addr_t       ex_target_i,
    // call push from decode
    input  logic                 id_push_valid_i,
    input  bpu_pkg::addr_t       id_push_data_i,
    input  logic                 stall_i,
    output logic                 is_ctrl_o,
    output logic                 pred_taken_o,
    output bpu_pkg::addr_t       pred_pc_o
);

    logic           if_branch, if_jal, if_jalr, if_ret;
    bpu_pkg::addr_t if_b_off, if_j_off;
    logic           ex_branch, ex_ret;
    logic           bim_taken;
    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    logic           ras_valid;
    bpu_pkg::addr_t ras_top;
    logic           ras_push, ras_pop;
    bpu_pkg::addr_t pc_plus4;

    inst_classify if_cls (
        .inst_i      (if_inst_i),
        .is_branch_o (if_branch),
        .is_jal_o    (if_jal),
        .is_jalr_o   (if_jalr),
        .is_ret_o    (if_ret),
        .b_offset_o  (if_b_off),
        .j_offset_o  (if_j_off)
    );

    // only the class matters at execute
    inst_classify ex_cls (
        .inst_i      (ex_inst_i),
        .is_branch_o (ex_branch),
        .is_jal_o    (),
        .is_jalr_o   (),
        .is_ret_o    (ex_ret),
        .b_offset_o  (),
        .j_offset_o  ()
    );

    bimodal_table u_bim (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .rd_taken_o  (bim_taken),
        .upd_valid_i (ex_valid_i && ex_branch),  // direction only for branches
        .upd_pc_i    (ex_pc_i),
        .upd_taken_i (ex_taken_i)
    );

    btb u_btb (
        .clk         (clk),
        .rst         (rst),
        .rd_pc_i     (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_valid_i  (ex_valid_i && ex_taken_i),  // allocate on taken
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    // stack frozen during stall
    assign ras_push = id_push_valid_i && !stall_i;
    assign ras_pop  = ex_valid_i && ex_taken_i && ex_ret && !stall_i;

    ras u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_data_i (id_push_data_i),
        .pop_i       (ras_pop),
        .top_valid_o (ras_valid),
        .top_o       (ras_top)
    );

    assign pc_plus4  = if_pc_i + bpu_pkg::addr_t'(4);
    assign is_ctrl_o = if_branch || if_jal || if_jalr;

    // prediction select
    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        if (if_ret) begin
            if (ras_valid) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top;
            end
        end else if (if_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit ? btb_target : if_pc_i + if_j_off;
        end else if (if_branch && bim_taken) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit ? btb_target : if_pc_i + if_b_off;
        end
        // plain jalr falls through as not taken
    end

endmodule

// File: design/btb.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t rd_pc_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o,
    input  logic           wr_valid_i,
    input  bpu_pkg::addr_t wr_pc_i,
    input  bpu_pkg::addr_t wr_target_i
);

    localparam int IDX_W = $clog2(`BPU_BTB_ENTRIES);
    localparam int TAG_W = `BPU_XLEN - IDX_W - 2;

    logic             valid_q  [`BPU_BTB_ENTRIES];
    logic [TAG_W-1:0] tag_q    [`BPU_BTB_ENTRIES];
    bpu_pkg::addr_t   target_q [`BPU_BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    assign rd_idx = rd_pc_i[IDX_W+1:2];
    assign rd_tag = rd_pc_i[`BPU_XLEN-1:IDX_W+2];
    assign wr_idx = wr_pc_i[IDX_W+1:2];
    assign wr_tag = wr_pc_i[`BPU_XLEN-1:IDX_W+2];

    // lookup
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BPU_BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target just follow the write, old entry is replaced
    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target_i;
        end
    end

endmodule

// File: design/inst_classify.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module inst_classify (
    input  bpu_pkg::inst_u inst_i,
    output logic           is_branch_o,
    output logic           is_jal_o,
    output logic           is_jalr_o,
    output logic           is_ret_o,
    output bpu_pkg::addr_t b_offset_o,
    output bpu_pkg::addr_t j_offset_o
);

    logic rs1_is_link;
    logic rd_is_zero;

    // opcode sits at the same place in every format
    assign is_branch_o = (inst_i.b_fmt.opcode == bpu_pkg::OP_BRANCH);
    assign is_jal_o    = (inst_i.j_fmt.opcode == bpu_pkg::OP_JAL);
    assign is_jalr_o   = (inst_i.i_fmt.opcode == bpu_pkg::OP_JALR);

    // ra or t0 as the link register
    assign rs1_is_link = (inst_i.i_fmt.rs1 == 5'd1) || (inst_i.i_fmt.rs1 == 5'd5);
    assign rd_is_zero  = (inst_i.i_fmt.rd == 5'd0);

    // jalr x0, 0(ra|t0)
    assign is_ret_o = is_jalr_o && rd_is_zero && rs1_is_link
                      && (inst_i.i_fmt.imm12 == 12'd0);

    // sign-extended B-type offset
    assign b_offset_o = {
        {(`BPU_XLEN-12){inst_i.b_fmt.imm12}},
        inst_i.b_fmt.imm11,
        inst_i.b_fmt.imm10_5,
        inst_i.b_fmt.imm4_1,
        1'b0
    };

    // sign-extended J-type offset
    assign j_offset_o = {
        {(`BPU_XLEN-20){inst_i.j_fmt.imm20}},
        inst_i.j_fmt.imm19_12,
        inst_i.j_fmt.imm11,
        inst_i.j_fmt.imm10_1,
        1'b0
    };

endmodule

// File: design/ras.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module ras (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  bpu_pkg::addr_t push_data_i,
    input  logic           pop_i,
    output logic           top_valid_o,
    output bpu_pkg::addr_t top_o
);

    localparam int PTR_W = $clog2(`BPU_RAS_DEPTH);
    localparam int SP_W  = $clog2(`BPU_RAS_DEPTH + 1);

    bpu_pkg::addr_t stack_q [`BPU_RAS_DEPTH];

    logic [SP_W-1:0]  sp_q;       // next free slot, 0 means empty
    logic [SP_W-1:0]  sp_popped;  // pointer after an eventual pop
    logic [SP_W-1:0]  sp_next;
    logic [PTR_W-1:0] top_idx;
    logic             empty;
    logic             push_ok;

    assign empty = (sp_q == '0);

    // pop is ignored on empty stack
    assign sp_popped = (pop_i && !empty) ? sp_q - SP_W'(1) : sp_q;

    // push after pop, dropped when full
    assign push_ok = push_i && (sp_popped < SP_W'(`BPU_RAS_DEPTH));
    assign sp_next = push_ok ? sp_popped + SP_W'(1) : sp_popped;

    assign top_idx = PTR_W'(sp_q - SP_W'(1));

    // same-cycle push is visible to the prediction
    assign top_valid_o = push_i || !empty;
    assign top_o       = push_i ? push_data_i : stack_q[top_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= sp_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            stack_q[sp_popped[PTR_W-1:0]] <= push_data_i;
        end
    end

endmodule

// File: filelist.f
+incdir+design
design/bpu_pkg.sv
design/inst_classify.sv
design/bimodal_table.sv
design/btb.sv
design/ras.sv
design/bpu_top.sv
tb/bpu_properties.sv
tb/bpu_checker.sv
tb/tb_bpu.sv

// File: tb/bpu_checker.sv
`timescale 1ns/1ps

module bpu_checker (
    input  logic           clk,
    input  logic           check_i,
    input  int             row_i,
    input  logic           exp_ctrl_i,
    input  logic           exp_taken_i,
    input  bpu_pkg::addr_t exp_pc_i,
    input  logic           is_ctrl_i,
    input  logic           pred_taken_i,
    input  bpu_pkg::addr_t pred_pc_i,
    output int             pass_cnt_o,
    output int             err_cnt_o
);

    int pass_cnt = 0;
    int err_cnt  = 0;

    assign pass_cnt_o = pass_cnt;
    assign err_cnt_o  = err_cnt;

    // mid-cycle, the combinational outputs have settled
    always @(negedge clk) begin
        if (check_i) begin
            if (is_ctrl_i !== exp_ctrl_i || pred_taken_i !== exp_taken_i
                || pred_pc_i !== exp_pc_i) begin
                err_cnt = err_cnt + 1;
                $display("[ERROR] t=%0t row %0d: got ctrl=%b taken=%b pc=%h, expected %b %b %h",
                         $time, row_i, is_ctrl_i, pred_taken_i, pred_pc_i,
                         exp_ctrl_i, exp_taken_i, exp_pc_i);
            end else begin
                pass_cnt = pass_cnt + 1;
                $display("row %0d ok: ctrl=%b taken=%b pc=%h",
                         row_i, is_ctrl_i, pred_taken_i, pred_pc_i);
            end
        end
    end

endmodule

// File: tb/bpu_properties.sv
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_properties #(
    parameter int SP_W = $clog2(`BPU_RAS_DEPTH + 1)
) (
    input logic            clk,
    input logic            rst,
    input logic [SP_W-1:0] sp_i,
    input bpu_pkg::addr_t  pc_i,
    input logic            is_ctrl_i,
    input logic            pred_taken_i,
    input bpu_pkg::addr_t  pred_pc_i
);

    // sp counts entries, a full stack sits at the depth itself
    sp_in_range: assert property (@(posedge clk) disable iff (rst)
        sp_i <= SP_W'(`BPU_RAS_DEPTH))
        else $error("ras stack pointer %0d beyond depth", sp_i);

    taken_needs_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_taken_i |-> is_ctrl_i)
        else $error("taken prediction on a non-control instruction");

    not_taken_seq: assert property (@(posedge clk) disable iff (rst)
        !pred_taken_i |-> (pred_pc_i == pc_i + 32'd4))
        else $error("not-taken prediction %h is not pc+4", pred_pc_i);

endmodule

// stack pointer taken from the ras inside the top
bind bpu_top bpu_properties props (
    .clk          (clk),
    .rst          (rst),
    .sp_i         (u_ras.sp_q),
    .pc_i         (if_pc_i),
    .is_ctrl_i    (is_ctrl_o),
    .pred_taken_i (pred_taken_o),
    .pred_pc_i    (pred_pc_o)
);

// File: tb/tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;

    localparam logic [31:0] BEQ_P16 = 32'h0020_8863;  // beq x1, x2, +16
    localparam logic [31:0] BEQ_M8  = 32'hfe20_8ce3;  // beq x1, x2, -8
    localparam logic [31:0] JAL_256 = 32'h1000_00ef;  // jal ra, +256
    localparam logic [31:0] RET     = 32'h0000_8067;  // jalr x0, 0(ra)
    localparam logic [31:0] JALR_T0 = 32'h0002_80e7;  // jalr ra, 0(t0) is not a return
    localparam logic [31:0] NOP     = 32'h0000_0013;

    typedef enum logic [2:0] {
        OP_PRED, OP_RAND, OP_UPD, OP_PUSH, OP_PUSH_PRED, OP_STALL_POP
    } op_e;

    typedef struct packed {
        op_e            op;
        bpu_pkg::addr_t pc;
        logic [31:0]    inst;
        logic           taken;
        bpu_pkg::addr_t target;
        bpu_pkg::addr_t push_data;
        logic           exp_ctrl;
        logic           exp_taken;
        bpu_pkg::addr_t exp_pc;
    } row_t;

    logic           clk = 1'b0;
    logic           rst;
    bpu_pkg::addr_t if_pc, ex_pc, ex_target, push_data, pred_pc, exp_pc;
    logic [31:0]    if_inst, ex_inst;
    logic           ex_valid, ex_taken, push_valid, stall;
    logic           is_ctrl, pred_taken, check, exp_ctrl, exp_taken;
    int             row_idx, pass_cnt, err_cnt;
    row_t           rows[$];
    logic [31:0]    lfsr = 32'hdd77e962;

    always #(CLK_PERIOD / 2) clk = ~clk;

    bpu_top uut (
        .clk (clk), .rst (rst),
        .if_pc_i (if_pc), .if_inst_i (if_inst),
        .ex_valid_i (ex_valid), .ex_taken_i (ex_taken), .ex_pc_i (ex_pc),
        .ex_inst_i (ex_inst), .ex_target_i (ex_target),
        .id_push_valid_i (push_valid), .id_push_data_i (push_data), .stall_i (stall),
        .is_ctrl_o (is_ctrl), .pred_taken_o (pred_taken), .pred_pc_o (pred_pc)
    );

    bpu_checker chk (
        .clk (clk), .check_i (check), .row_i (row_idx),
        .exp_ctrl_i (exp_ctrl), .exp_taken_i (exp_taken), .exp_pc_i (exp_pc),
        .is_ctrl_i (is_ctrl), .pred_taken_i (pred_taken), .pred_pc_i (pred_pc),
        .pass_cnt_o (pass_cnt), .err_cnt_o (err_cnt)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic add_row(input op_e op, input bpu_pkg::addr_t pc, input logic [31:0] inst,
                           input logic tk, input bpu_pkg::addr_t tgt, input bpu_pkg::addr_t psh,
                           input logic e_ctrl, input logic e_taken, input bpu_pkg::addr_t e_pc);
        rows.push_back('{op, pc, inst, tk, tgt, psh, e_ctrl, e_taken, e_pc});
    endtask

    task automatic build_table();
        // cold predictor
        add_row(OP_PRED,  32'h1000, BEQ_P16, 1'b0, 32'h0,    32'h0, 1'b1, 1'b0, 32'h1004);
        add_row(OP_RAND,  32'h0,    NOP,     1'b0, 32'h0,    32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h1200, JALR_T0, 1'b0, 32'h0,    32'h0, 1'b1, 1'b0, 32'h1204);
        // jal with immediate target then btb target
        add_row(OP_PRED,  32'h2000, JAL_256, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h2100);
        add_row(OP_UPD,   32'h2000, JAL_256, 1'b1, 32'h3000, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h2000, JAL_256, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h3000);
        // training then an alias that shares the counter but not the tag
        add_row(OP_UPD,   32'h1048, BEQ_P16, 1'b1, 32'h1800, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_UPD,   32'h1048, BEQ_P16, 1'b1, 32'h1800, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h1048, BEQ_P16, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h1800);
        add_row(OP_PRED,  32'h1148, BEQ_M8,  1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h1140);
        // hysteresis of the 2-bit counter
        add_row(OP_UPD,   32'h1080, BEQ_P16, 1'b1, 32'h1400, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_UPD,   32'h1080, BEQ_P16, 1'b1, 32'h1400, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_UPD,   32'h1080, BEQ_P16, 1'b1, 32'h1400, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_UPD,   32'h1080, BEQ_P16, 1'b0, 32'h1084, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h1080, BEQ_P16, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h1400);
        add_row(OP_UPD,   32'h1080, BEQ_P16, 1'b0, 32'h1084, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h1080, BEQ_P16, 1'b0, 32'h0,    32'h0, 1'b1, 1'b0, 32'h1084);
        // return stack
        add_row(OP_PUSH,  32'h0, NOP, 1'b0, 32'h0,    32'h4004, 1'b0, 1'b0, 32'h0);
        add_row(OP_PUSH,  32'h0, NOP, 1'b0, 32'h0,    32'h4104, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h4104);
        add_row(OP_UPD,   32'h5000, RET, 1'b1, 32'h4104, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h4004);
        add_row(OP_STALL_POP, 32'h5000, RET, 1'b1, 32'h4004, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h4004);
        add_row(OP_UPD,   32'h5000, RET, 1'b1, 32'h4004, 32'h0, 1'b0, 1'b0, 32'h0);
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b0, 32'h5004);
        add_row(OP_PUSH_PRED, 32'h5000, RET, 1'b0, 32'h0, 32'h4208, 1'b1, 1'b1, 32'h4208);
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h4208);
        // one entry held, seven more fill the stack and the eighth push is dropped
        for (int k = 0; k < 8; k++) begin
            add_row(OP_PUSH, 32'h0, NOP, 1'b0, 32'h0, 32'h6004 + 32'h100 * k,
                    1'b0, 1'b0, 32'h0);
        end
        add_row(OP_PRED,  32'h5000, RET, 1'b0, 32'h0,    32'h0, 1'b1, 1'b1, 32'h6604);
        add_row(OP_RAND,  32'h0,    NOP, 1'b0, 32'h0,    32'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic idle_inputs();
        if_pc      = '0;
        if_inst    = NOP;
        ex_valid   = 1'b0;
        ex_taken   = 1'b0;
        ex_pc      = '0;
        ex_inst    = NOP;
        ex_target  = '0;
        push_valid = 1'b0;
        push_data  = '0;
        stall      = 1'b0;
        check      = 1'b0;
    endtask

    task automatic apply_row(input row_t r, input int idx);
        logic [31:0] rnd;
        @(posedge clk);
        #1;
        idle_inputs();
        row_idx   = idx;
        exp_ctrl  = r.exp_ctrl;
        exp_taken = r.exp_taken;
        exp_pc    = r.exp_pc;
        case (r.op)
            OP_PRED, OP_PUSH_PRED: begin
                if_pc   = r.pc;
                if_inst = r.inst;
            end
            OP_RAND: begin
                take_bits(30, rnd);
                if_pc = {rnd[29:0], 2'b00};
                take_bits(25, rnd);
                if_inst = {rnd[24:0], 7'b0010011};  // op-imm is never a control transfer
                exp_pc  = if_pc + 32'd4;
            end
            OP_UPD, OP_STALL_POP: begin
                ex_valid  = 1'b1;
                ex_taken  = r.taken;
                ex_pc     = r.pc;
                ex_inst   = r.inst;
                ex_target = r.target;
                stall     = (r.op == OP_STALL_POP);
            end
            default: ;
        endcase
        push_valid = (r.op == OP_PUSH || r.op == OP_PUSH_PRED);
        push_data  = r.push_data;
        check      = (r.op == OP_PRED || r.op == OP_PUSH_PRED || r.op == OP_RAND);
    endtask

    initial begin
        idle_inputs();
        row_idx   = 0;
        exp_ctrl  = 1'b0;
        exp_taken = 1'b0;
        exp_pc    = '0;
        rst       = 1'b1;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i], i);
        end
        @(posedge clk);  // last check happened at the falling edge before
        #1 idle_inputs();
        @(posedge clk);
        $display("rows checked: %0d, passed: %0d, errors: %0d",
                 pass_cnt + err_cnt, pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // run length is one clock per row plus reset and some slack
    initial begin
        int limit_ns;
        #1;
        limit_ns = (rows.size() + RESET_CYCLES + 20) * CLK_PERIOD;
        #(limit_ns);
        $display("timeout: the stimulus did not finish within %0d ns", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule
